// ==== include/lin_params.svh ====
/* Build-time sizes shared by the whole linearizer.
   Channel and segment counts must be powers of two */
`ifndef LIN_PARAMS_SVH
`define LIN_PARAMS_SVH

// Width of a raw sample and of a linearized result
`define LIN_DATA_WIDTH 16

// Number of independent sensor channels
`define LIN_N_CHANNELS 4

// Segments per channel, each with one bound and one gain
`define LIN_N_SEGMENTS 4

// Width of a channel number
`define LIN_CH_WIDTH ($clog2(`LIN_N_CHANNELS))

// Width of a segment number
`define LIN_SEG_WIDTH ($clog2(`LIN_N_SEGMENTS))

// Entry index covers all bounds followed by all gains of one channel
`define LIN_ENTRY_WIDTH ($clog2(2 * `LIN_N_SEGMENTS))

`endif

// ==== src/lin_pkg.sv ====
/* Types shared by the linearizer modules; widths come from lin_params.svh.
   Gains are unsigned Q1.16, so the largest gain is just below 2.0 */
`include "lin_params.svh"

package lin_pkg;

    typedef logic [`LIN_DATA_WIDTH-1:0] sample_t;

    // One integer bit and LIN_DATA_WIDTH fraction bits, 1.0 is 2**16
    typedef logic [`LIN_DATA_WIDTH:0] gain_t;

    typedef logic [`LIN_CH_WIDTH-1:0] channel_t;

    typedef logic [`LIN_SEG_WIDTH-1:0] segment_t;

    // Entries 0..N-1 are the bounds, entries N..2N-1 are the gains
    typedef logic [`LIN_ENTRY_WIDTH-1:0] entry_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CONFIG,
        ST_RUN
    } seq_state_t;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_CONFIG = 3'd1,
        OP_SELECT = 3'd2,
        OP_WRITE  = 3'd3,
        OP_START  = 3'd4,
        OP_STOP   = 3'd5
    } cfg_opcode_t;

endpackage

// ==== src/cal_sequencer.sv ====
/* Calibration command sequencer. Writes and selects are honoured only in CONFIG;
   the write and clear pulses are combinational so the table updates on the command edge */
`timescale 1ns/1ps

module cal_sequencer
    import lin_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        cfg_valid,
    input  cfg_opcode_t cfg_opcode,
    input  sample_t     cfg_data,
    output logic        running,
    output logic        entry_write,
    output channel_t    write_channel,
    output sample_t     write_data,
    output logic        index_clear
);

    seq_state_t state;
    seq_state_t state_next;
    logic       in_config;

    assign in_config = (state == ST_CONFIG);

    always_comb begin
        state_next = state;
        if (cfg_valid) begin
            case (cfg_opcode)
                // Entering CONFIG from CONFIG is harmless, so no state check
                OP_CONFIG: state_next = ST_CONFIG;
                OP_START: begin
                    if (in_config) begin
                        state_next = ST_RUN;
                    end
                end
                OP_STOP:   state_next = ST_IDLE;
                default:   state_next = state;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Table access strobes, only while configuring
    assign entry_write = cfg_valid && in_config && (cfg_opcode == OP_WRITE);
    assign index_clear = cfg_valid && in_config && (cfg_opcode == OP_SELECT);
    assign write_data  = cfg_data;

    // The selected channel stays until the next SELECT
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_channel <= '0;
        end else if (index_clear) begin
            write_channel <= channel_t'(cfg_data);
        end
    end

    assign running = (state == ST_RUN);

    a_state_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        state inside {ST_IDLE, ST_CONFIG, ST_RUN}
    );

endmodule

// ==== src/table_index_counter.sv ====
/* Entry pointer for calibration writes. Wraps after the last gain,
   so a ninth write without SELECT lands on bound 0 again */
`timescale 1ns/1ps
`include "lin_params.svh"

module table_index_counter
    import lin_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   entry_write,
    input  logic   index_clear,
    output entry_t entry_index
);

    localparam entry_t LAST_ENTRY = entry_t'(2 * `LIN_N_SEGMENTS - 1);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            entry_index <= '0;
        end else if (index_clear) begin
            entry_index <= '0;
        end else if (entry_write) begin
            if (entry_index == LAST_ENTRY) begin
                entry_index <= '0;
            end else begin
                entry_index <= entry_index + 1'b1;
            end
        end
    end

    // Both pulses come from one decoded opcode in the sequencer
    a_write_clear_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(entry_write && index_clear)
    );

endmodule

// ==== src/cal_table.sv ====
/* Bound and gain registers for every channel. Gain writes take 16-bit Q1.15 data and
   append a zero fraction bit, so only gains below 2.0 can be loaded. Reads are combinational */
`timescale 1ns/1ps
`include "lin_params.svh"

module cal_table
    import lin_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          entry_write,
    input  channel_t                      write_channel,
    input  sample_t                       write_data,
    input  entry_t                        entry_index,
    input  channel_t                      read_channel,
    output sample_t [`LIN_N_SEGMENTS-1:0] bound_row,
    input  channel_t                      gain_channel,
    input  segment_t                      gain_segment,
    output gain_t                         gain
);

    sample_t [`LIN_N_SEGMENTS-1:0] bounds [`LIN_N_CHANNELS];
    gain_t   [`LIN_N_SEGMENTS-1:0] gains  [`LIN_N_CHANNELS];

    logic     is_gain;
    segment_t entry_segment;

    // Upper half of the index range addresses gains
    assign is_gain = (entry_index >= entry_t'(`LIN_N_SEGMENTS));

    // With a power-of-two segment count the low bits give the segment in both halves
    assign entry_segment = segment_t'(entry_index);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int c = 0; c < `LIN_N_CHANNELS; c++) begin
                bounds[c] <= '0;
                gains[c]  <= '0;
            end
        end else if (entry_write) begin
            if (is_gain) begin
                // Written gain is Q1.15, a zero bit below turns it into Q1.16
                gains[write_channel][entry_segment] <= {write_data, 1'b0};
            end else begin
                bounds[write_channel][entry_segment] <= write_data;
            end
        end
    end

    // Stage 1 needs the whole bound row of the incoming channel
    assign bound_row = bounds[read_channel];

    // Stage 2 needs one gain, picked by the registered channel and segment
    assign gain = gains[gain_channel][gain_segment];

endmodule

// ==== src/segment_select.sv ====
/* First pipeline stage. Bounds are assumed ascending; a sample below bound 0
   falls into segment 0. The mode is captured with each sample */
`timescale 1ns/1ps
`include "lin_params.svh"

module segment_select
    import lin_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  channel_t                      in_channel,
    input  sample_t                       in_data,
    input  logic                          running,
    input  sample_t [`LIN_N_SEGMENTS-1:0] bound_row,
    output logic                          s1_valid,
    output channel_t                      s1_channel,
    output sample_t                       s1_data,
    output segment_t                      s1_segment,
    output logic                          s1_linearize
);

    logic [`LIN_N_SEGMENTS-1:0] at_or_above;
    segment_t                   segment;

    // One comparator per bound of the sample's channel
    always_comb begin
        for (int k = 0; k < `LIN_N_SEGMENTS; k++) begin
            at_or_above[k] = (in_data >= bound_row[k]);
        end
    end

    // The highest bound reached selects the segment
    always_comb begin
        segment = '0;
        for (int k = 0; k < `LIN_N_SEGMENTS; k++) begin
            if (at_or_above[k]) begin
                segment = segment_t'(k);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            s1_channel   <= in_channel;
            s1_data      <= in_data;
            s1_segment   <= segment;
            s1_linearize <= running;
        end
    end

endmodule

// ==== src/gain_multiplier.sv ====
/* Second pipeline stage. Result is data times a Q1.16 gain, shifted right by 16
   and clipped to full scale; samples taken in bypass pass unchanged */
`timescale 1ns/1ps
`include "lin_params.svh"

module gain_multiplier
    import lin_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     s1_valid,
    input  channel_t s1_channel,
    input  sample_t  s1_data,
    input  segment_t s1_segment,
    input  logic     s1_linearize,
    input  gain_t    gain,
    output logic     out_valid,
    output channel_t out_channel,
    output sample_t  out_data
);

    localparam int W = `LIN_DATA_WIDTH;

    logic [2*W:0] product;
    logic [W:0]   scaled;
    sample_t      result;

    // Full-width product, then drop the fraction bits
    assign product = s1_data * gain;
    assign scaled  = product[2*W:W];

    always_comb begin
        if (!s1_linearize) begin
            result = s1_data;
        end else if (scaled[W]) begin
            // Gains near 2.0 can overflow the output range
            result = '1;
        end else begin
            result = scaled[W-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            out_channel <= s1_channel;
            out_data    <= result;
        end
    end

    // Stage 1 valid feeds through here, so an X would show up here too
    a_out_valid_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(out_valid)
    );

endmodule

// ==== src/linearizer_top.sv ====
/* Multi-channel sensor linearizer with a fixed 2-cycle latency and no back-pressure.
   Downstream logic must take each result in the cycle out_valid is high */
`timescale 1ns/1ps
`include "lin_params.svh"

module linearizer_top
    import lin_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        in_valid,
    input  channel_t    in_channel,
    input  sample_t     in_data,
    output logic        out_valid,
    output channel_t    out_channel,
    output sample_t     out_data,
    input  logic        cfg_valid,
    input  cfg_opcode_t cfg_opcode,
    input  sample_t     cfg_data,
    output logic        running
);

    logic                          entry_write;
    logic                          index_clear;
    channel_t                      write_channel;
    sample_t                       write_data;
    entry_t                        entry_index;
    sample_t [`LIN_N_SEGMENTS-1:0] bound_row;
    gain_t                         gain;

    logic                          s1_valid;
    channel_t                      s1_channel;
    sample_t                       s1_data;
    segment_t                      s1_segment;
    logic                          s1_linearize;

    cal_sequencer cal_sequencer_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .cfg_valid     (cfg_valid),
        .cfg_opcode    (cfg_opcode),
        .cfg_data      (cfg_data),
        .running       (running),
        .entry_write   (entry_write),
        .write_channel (write_channel),
        .write_data    (write_data),
        .index_clear   (index_clear)
    );

    table_index_counter table_index_counter_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .entry_write (entry_write),
        .index_clear (index_clear),
        .entry_index (entry_index)
    );

    // Bounds follow the incoming sample, the gain follows stage 1
    cal_table cal_table_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .entry_write   (entry_write),
        .write_channel (write_channel),
        .write_data    (write_data),
        .entry_index   (entry_index),
        .read_channel  (in_channel),
        .bound_row     (bound_row),
        .gain_channel  (s1_channel),
        .gain_segment  (s1_segment),
        .gain          (gain)
    );

    segment_select segment_select_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_channel   (in_channel),
        .in_data      (in_data),
        .running      (running),
        .bound_row    (bound_row),
        .s1_valid     (s1_valid),
        .s1_channel   (s1_channel),
        .s1_data      (s1_data),
        .s1_segment   (s1_segment),
        .s1_linearize (s1_linearize)
    );

    gain_multiplier gain_multiplier_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .s1_channel   (s1_channel),
        .s1_data      (s1_data),
        .s1_segment   (s1_segment),
        .s1_linearize (s1_linearize),
        .gain         (gain),
        .out_valid    (out_valid),
        .out_channel  (out_channel),
        .out_data     (out_data)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
/* Free-running testbench clock, 40 ns period, starting low at time zero */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock
);

    localparam realtime HALF_PERIOD = 20ns;

    initial begin
        clock = 1'b0;
        forever begin
            #HALF_PERIOD clock = ~clock;
        end
    end

endmodule

// ==== test/tb_linearizer.sv ====
/* Testbench for linearizer_top. A model of the tables and the command rules tracks
   the DUT, and expected results are queued at input time with their start cycle */
`timescale 1ns/1ps
`include "lin_params.svh"

module tb_linearizer
    import lin_pkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int N_CH = `LIN_N_CHANNELS;
    localparam int N_SEG = `LIN_N_SEGMENTS;

    logic        clock;
    logic        rst_n;
    logic        in_valid;
    channel_t    in_channel;
    sample_t     in_data;
    logic        out_valid;
    channel_t    out_channel;
    sample_t     out_data;
    logic        cfg_valid;
    cfg_opcode_t cfg_opcode;
    sample_t     cfg_data;
    logic        running;

    // Model of the calibration state, updated as commands are driven
    sample_t    ref_bounds [N_CH][N_SEG];
    gain_t      ref_gains  [N_CH][N_SEG];
    seq_state_t model_state;
    channel_t   model_channel;
    int         model_index;

    channel_t exp_channel [$];
    sample_t  exp_data [$];
    int       exp_cycle [$];
    channel_t popped_channel;
    sample_t  popped_data;
    int       popped_cycle;

    int cycle;
    int checks;
    int errors;
    int test_start;

    tb_clock_gen tb_clock_gen_i (
        .clock (clock)
    );

    linearizer_top linearizer_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_channel  (in_channel),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_channel (out_channel),
        .out_data    (out_data),
        .cfg_valid   (cfg_valid),
        .cfg_opcode  (cfg_opcode),
        .cfg_data    (cfg_data),
        .running     (running)
    );

    // Segment is the highest bound reached, the result is clipped to full scale
    function automatic sample_t expected_output(input sample_t data, input channel_t ch,
                                                input logic linearize);
        int                         seg;
        logic [2*`LIN_DATA_WIDTH:0] product;
        logic [`LIN_DATA_WIDTH:0]   scaled;
        seg = 0;
        for (int k = 0; k < N_SEG; k++) begin
            if (data >= ref_bounds[ch][k]) begin
                seg = k;
            end
        end
        if (!linearize) begin
            return data;
        end
        product = data * ref_gains[ch][seg];
        scaled = product >> `LIN_DATA_WIDTH;
        if (scaled > 17'h0ffff) begin
            return 16'hffff;
        end
        return scaled[`LIN_DATA_WIDTH-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic model_command(input cfg_opcode_t op, input sample_t data);
        case (op)
            OP_CONFIG: model_state = ST_CONFIG;
            OP_SELECT: begin
                if (model_state == ST_CONFIG) begin
                    model_channel = channel_t'(data);
                    model_index = 0;
                end
            end
            OP_WRITE: begin
                if (model_state == ST_CONFIG) begin
                    if (model_index < N_SEG) begin
                        ref_bounds[model_channel][model_index] = data;
                    end else begin
                        // Gain data is written as Q1.15
                        ref_gains[model_channel][model_index - N_SEG] = {data, 1'b0};
                    end
                    model_index = (model_index + 1) % (2 * N_SEG);
                end
            end
            OP_START: begin
                if (model_state == ST_CONFIG) begin
                    model_state = ST_RUN;
                end
            end
            OP_STOP: model_state = ST_IDLE;
            default: ;
        endcase
    endtask

    // A sample driven with a command still sees the mode and tables before it
    task automatic drive_cycle(input logic s_valid, input channel_t s_ch, input sample_t s_data,
                               input logic c_valid, input cfg_opcode_t op, input sample_t c_data);
        @(posedge clock);
        in_valid   <= s_valid;
        in_channel <= s_ch;
        in_data    <= s_data;
        cfg_valid  <= c_valid;
        cfg_opcode <= op;
        cfg_data   <= c_data;
        if (s_valid) begin
            exp_channel.push_back(s_ch);
            exp_data.push_back(expected_output(s_data, s_ch, model_state == ST_RUN));
            exp_cycle.push_back(cycle);
        end
        if (c_valid) begin
            model_command(op, c_data);
        end
    endtask

    task automatic send_sample(input channel_t ch, input sample_t data);
        drive_cycle(1'b1, ch, data, 1'b0, OP_NOP, '0);
    endtask

    task automatic send_command(input cfg_opcode_t op, input sample_t data);
        drive_cycle(1'b0, '0, '0, 1'b1, op, data);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, OP_NOP, '0);
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_data.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic check_running(input logic expected);
        idle_cycle();
        @(negedge clock);
        check_value("running", running, expected);
    endtask

    task automatic finish_test(input string name);
        $display("%-16s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // Ascending bounds starting at 1 or more, then gains below 2.0
    task automatic load_random_channel(input channel_t ch);
        sample_t bound;
        bound = sample_t'(1 + $urandom % 16'h1000);
        send_command(OP_SELECT, sample_t'(ch));
        for (int k = 0; k < N_SEG; k++) begin
            send_command(OP_WRITE, bound);
            bound = bound + sample_t'(1 + $urandom % 16'h4000);
        end
        for (int k = 0; k < N_SEG; k++) begin
            send_command(OP_WRITE, sample_t'($urandom % 17'h10000));
        end
    endtask

    task automatic test_segment_edges();
        for (int c = 0; c < N_CH; c++) begin
            send_sample(channel_t'(c), '0);
            for (int k = 0; k < N_SEG; k++) begin
                send_sample(channel_t'(c), ref_bounds[c][k]);
                send_sample(channel_t'(c), ref_bounds[c][k] - 1'b1);
            end
        end
        drain();
    endtask

    // Gains just under 2.0 push samples near full scale past the output range
    task automatic test_full_scale();
        send_command(OP_CONFIG, '0);
        send_command(OP_SELECT, 16'd2);
        send_command(OP_WRITE, 16'h0100);
        send_command(OP_WRITE, 16'h4000);
        send_command(OP_WRITE, 16'h8000);
        send_command(OP_WRITE, 16'hc000);
        send_command(OP_WRITE, 16'hffff);
        send_command(OP_WRITE, 16'hff00);
        send_command(OP_WRITE, 16'hfff0);
        send_command(OP_WRITE, 16'hffff);
        send_command(OP_START, '0);
        check_running(1'b1);
        send_sample(2'd2, 16'hffff);
        send_sample(2'd2, 16'hfffe);
        send_sample(2'd2, 16'hc000);
        send_sample(2'd2, 16'hbfff);
        send_sample(2'd2, 16'h8000);
        send_sample(2'd2, 16'h00ff);
        for (int c = 0; c < N_CH; c++) begin
            send_sample(channel_t'(c), 16'hffff);
        end
        drain();
    endtask

    task automatic test_command_rules();
        sample_t b0;
        sample_t b1;
        sample_t new_b1;
        // A stray write would land on bound 0 and then bound 1 of channel 2
        send_command(OP_WRITE, 16'h1234);
        send_command(OP_WRITE, 16'h1234);
        for (int c = 0; c < N_CH; c++) begin
            send_sample(channel_t'(c), ref_bounds[c][1] - 1'b1);
            send_sample(channel_t'(c), sample_t'($urandom));
        end
        send_command(OP_STOP, '0);
        send_sample(2'd3, 16'h9abc);
        check_running(1'b0);
        drain();
        b0 = ref_bounds[1][0];
        b1 = ref_bounds[1][1];
        new_b1 = b0 + (b1 - b0) / 2;
        send_command(OP_CONFIG, '0);
        send_command(OP_SELECT, 16'd1);
        send_command(OP_WRITE, b0);
        send_command(OP_WRITE, b1);
        send_command(OP_WRITE, ref_bounds[1][2]);
        // Reselecting must send the next writes to bound 0 and bound 1 again
        send_command(OP_SELECT, 16'd1);
        send_command(OP_WRITE, b0);
        send_command(OP_WRITE, new_b1);
        send_command(OP_START, '0);
        check_running(1'b1);
        send_sample(2'd1, new_b1);
        send_sample(2'd1, new_b1 - 1'b1);
        send_sample(2'd1, b1 - 1'b1);
        send_sample(2'd1, ref_bounds[1][3]);
        drain();
    endtask

    // Modes switch mid-stream while samples keep entering every cycle
    task automatic test_throughput();
        for (int i = 0; i < 48; i++) begin
            if (i == 15) begin
                drive_cycle(1'b1, channel_t'(i), sample_t'($urandom), 1'b1, OP_STOP, '0);
            end else if (i == 28) begin
                drive_cycle(1'b1, channel_t'(i), sample_t'($urandom), 1'b1, OP_CONFIG, '0);
            end else if (i == 29) begin
                drive_cycle(1'b1, channel_t'(i), sample_t'($urandom), 1'b1, OP_START, '0);
            end else begin
                send_sample(channel_t'(i), sample_t'($urandom));
            end
        end
        drain();
    endtask

    always @(negedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (rst_n && out_valid === 1'b1) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("out_valid was high with no sample in flight, channel 0x%0h data 0x%0h",
                         out_channel, out_data);
            end else begin
                popped_channel = exp_channel.pop_front();
                popped_data = exp_data.pop_front();
                popped_cycle = exp_cycle.pop_front();
                if (cycle - popped_cycle != 2) begin
                    errors++;
                    $display("Result arrived after %0d cycles instead of 2",
                             cycle - popped_cycle);
                end
                check_value("out_channel", out_channel, popped_channel);
                check_value("out_data", out_data, popped_data);
            end
        end
    end

    initial begin
        void'($urandom(32'hbc32_f7fc));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_channel = '0;
        in_data = '0;
        cfg_valid = 1'b0;
        cfg_opcode = OP_NOP;
        cfg_data = '0;
        cycle = 0;
        checks = 0;
        errors = 0;
        test_start = 0;
        model_state = ST_IDLE;
        model_channel = '0;
        model_index = 0;
        for (int c = 0; c < N_CH; c++) begin
            for (int k = 0; k < N_SEG; k++) begin
                ref_bounds[c][k] = '0;
                ref_gains[c][k] = '0;
            end
        end
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;

        @(negedge clock);
        check_value("out_valid", out_valid, 1'b0);
        check_running(1'b0);
        for (int i = 0; i < 32; i++) begin
            send_sample(channel_t'($urandom), sample_t'($urandom));
        end
        drain();
        finish_test("bypass");

        send_command(OP_CONFIG, '0);
        for (int c = 0; c < N_CH; c++) begin
            load_random_channel(channel_t'(c));
        end
        send_command(OP_START, '0);
        check_running(1'b1);
        for (int i = 0; i < 100; i++) begin
            send_sample(channel_t'($urandom), sample_t'($urandom));
        end
        drain();
        finish_test("load_linearize");

        test_segment_edges();
        finish_test("segment_edges");
        test_full_scale();
        finish_test("full_scale");
        test_command_rules();
        finish_test("command_rules");
        test_throughput();
        finish_test("throughput");

        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycle);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
src/lin_pkg.sv
src/cal_sequencer.sv
src/table_index_counter.sv
src/cal_table.sv
src/segment_select.sv
src/gain_multiplier.sv
src/linearizer_top.sv
test/tb_clock_gen.sv
test/tb_linearizer.sv

// ==== Bender.yml ====
package:
  name: sensor_linearizer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/lin_pkg.sv
      - src/cal_sequencer.sv
      - src/table_index_counter.sv
      - src/cal_table.sv
      - src/segment_select.sv
      - src/gain_multiplier.sv
      - src/linearizer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock_gen.sv
      - test/tb_linearizer.sv
